// ==== dcache_defs.svh ====
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

`default_nettype none

// Word and address widths
`define DATA_W 32
`define ADDR_W 32

// 4 sets, one word per line
`define SET_W 2
`define TAG_W (`ADDR_W - `SET_W - 2)

// Uncached word, always goes to memory
`define MMIO_ADDR 32'h000000FC

`define MEM_WORDS 256  // Main memory depth in words
`define MEM_WAIT 2     // Wait states per APB access

`default_nettype wire

`endif

// ==== dcache_pkg.sv ====
`include "dcache_defs.svh"
`default_nettype none

package dcache_pkg;

    // One address word, seen either raw or split into cache fields
    typedef union packed {
        logic [`ADDR_W-1:0] raw;  // MMIO compare and APB address
        struct packed {
            logic [`TAG_W-1:0] tag;
            logic [`SET_W-1:0] setIdx;
            logic [1:0]        offset;  // Byte within the word
        } f;
    } cacheAddrT;

endpackage

`default_nettype wire

// ==== cacheIfs.sv ====
`include "dcache_defs.svh"
`timescale 1ns/10ps
`default_nettype none

// APB link from miss controller to main memory
interface apbIf;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [`ADDR_W-1:0] paddr;
    logic [`DATA_W-1:0] pwdata;
    logic [`DATA_W-1:0] prdata;
    logic               pready;

    modport master (
        output psel, penable, pwrite, paddr, pwdata,
        input  prdata, pready
    );

    modport slave (
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready
    );
endinterface

// Miss handshake between the array and the controller
interface missIf;
    logic               missReq;      // Level, held while the access misses
    logic               victimDirty;
    logic [`ADDR_W-1:0] victimAddr;
    logic [`DATA_W-1:0] victimData;
    logic               fillValid;    // One cycle pulse
    logic [`DATA_W-1:0] fillData;

    modport cache (
        output missReq, victimDirty, victimAddr, victimData,
        input  fillValid, fillData
    );

    modport ctrl (
        input  missReq, victimDirty, victimAddr, victimData,
        output fillValid, fillData
    );
endinterface

`default_nettype wire

// ==== loadStoreAlign.sv ====
`include "dcache_defs.svh"
`timescale 1ns/10ps
`default_nettype none

module loadStoreAlign (
    input  logic [2:0]         funct3,
    input  logic [1:0]         offset,
    input  logic [`DATA_W-1:0] lineWord,
    input  logic [`DATA_W-1:0] wdata,
    output logic [`DATA_W-1:0] loadData,
    output logic [`DATA_W-1:0] storeWord,
    output logic [3:0]         byteEnable
);
    logic [7:0]  loadByte;
    logic [15:0] loadHalf;

    assign loadByte = lineWord[{offset, 3'b000} +: 8];
    assign loadHalf = lineWord[{offset[1], 4'b0000} +: 16];  // Halfword follows bit 1

    always_comb begin
        case (funct3)
            3'b000: begin  // lb
                loadData = {{(`DATA_W-8){loadByte[7]}}, loadByte};
            end
            3'b001: begin  // lh
                loadData = {{(`DATA_W-16){loadHalf[15]}}, loadHalf};
            end
            3'b010:  loadData = lineWord;                           // lw
            3'b100:  loadData = {{(`DATA_W-8){1'b0}}, loadByte};    // lbu
            3'b101:  loadData = {{(`DATA_W-16){1'b0}}, loadHalf};   // lhu
            default: loadData = '0;
        endcase
    end

    // Data is copied into every lane, the enables pick the lanes that land
    always_comb begin
        case (funct3)
            3'b000: begin  // sb
                storeWord  = {4{wdata[7:0]}};
                byteEnable = 4'b0001 << offset;
            end
            3'b001: begin  // sh
                storeWord  = {2{wdata[15:0]}};
                byteEnable = offset[1] ? 4'b1100 : 4'b0011;
            end
            3'b010: begin  // sw
                storeWord  = wdata;
                byteEnable = 4'b1111;
            end
            default: begin
                storeWord  = wdata;
                byteEnable = 4'b0000;  // Nothing written
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== cacheArray.sv ====
`include "dcache_defs.svh"
`timescale 1ns/10ps
`default_nettype none

module cacheArray (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  read,
    input  logic                  write,
    input  dcache_pkg::cacheAddrT addr,
    input  logic [`DATA_W-1:0]    storeWord,
    input  logic [3:0]            byteEnable,
    output logic [`DATA_W-1:0]    lineWord,
    output logic                  hit,
    missIf.cache                  miss
);
    import dcache_pkg::*;

    localparam int Sets = 1 << `SET_W;

    logic [1:0]         valid [Sets];    // Bit per way
    logic [1:0]         dirty [Sets];
    logic [Sets-1:0]    lru;             // Way to replace next
    logic [`TAG_W-1:0]  tags  [Sets][2];
    logic [`DATA_W-1:0] data  [Sets][2];

    logic [`SET_W-1:0]  setIdx;
    logic [`TAG_W-1:0]  tag;
    logic               access;
    logic               isMmio;
    logic               hit0;
    logic               hit1;
    logic               wayHit;
    logic               victimWay;
    logic [`DATA_W-1:0] mergedWord;
    cacheAddrT          victim;

    assign setIdx = addr.f.setIdx;
    assign tag    = addr.f.tag;
    assign access = read | write;
    assign isMmio = (addr.raw == `MMIO_ADDR);

    assign hit0      = valid[setIdx][0] && (tags[setIdx][0] == tag);
    assign hit1      = valid[setIdx][1] && (tags[setIdx][1] == tag);
    assign wayHit    = ~hit0;  // Way 0 wins
    assign hit       = access && !isMmio && (hit0 || hit1);
    assign lineWord  = data[setIdx][wayHit];
    assign victimWay = lru[setIdx];

    // Store merge under byte enables
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            mergedWord[8*b +: 8] = byteEnable[b] ? storeWord[8*b +: 8] : lineWord[8*b +: 8];
        end
    end

    // Victim address rebuilt from its stored tag
    always_comb begin
        victim.f.tag    = tags[setIdx][victimWay];
        victim.f.setIdx = setIdx;
        victim.f.offset = 2'b00;
    end

    assign miss.missReq     = access && !isMmio && !(hit0 || hit1);
    assign miss.victimDirty = valid[setIdx][victimWay] && dirty[setIdx][victimWay];
    assign miss.victimAddr  = victim.raw;
    assign miss.victimData  = data[setIdx][victimWay];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < Sets; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
            end
            lru <= '0;
        end else if (miss.fillValid) begin
            valid[setIdx][victimWay] <= 1'b1;
            dirty[setIdx][victimWay] <= 1'b0;  // Fresh copy of memory
            lru[setIdx]              <= ~victimWay;
        end else if (hit) begin
            lru[setIdx] <= ~wayHit;
            if (write) begin
                dirty[setIdx][wayHit] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (miss.fillValid) begin
            tags[setIdx][victimWay] <= tag;
            data[setIdx][victimWay] <= miss.fillData;
        end else if (hit && write) begin
            data[setIdx][wayHit] <= mergedWord;
        end
    end

endmodule

`default_nettype wire

// ==== missController.sv ====
`include "dcache_defs.svh"
`timescale 1ns/10ps
`default_nettype none

module missController (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  read,
    input  logic                  write,
    input  dcache_pkg::cacheAddrT addr,
    input  logic [`DATA_W-1:0]    storeWord,
    output logic [`DATA_W-1:0]    mmioData,
    output logic                  mmioBusy,
    missIf.ctrl                   miss,
    apbIf.master                  apb
);
    import dcache_pkg::*;

    localparam logic [2:0] Idle       = 3'd0;
    localparam logic [2:0] WbSetup    = 3'd1;
    localparam logic [2:0] WbAccess   = 3'd2;
    localparam logic [2:0] FillSetup  = 3'd3;
    localparam logic [2:0] FillAccess = 3'd4;
    localparam logic [2:0] MmioSetup  = 3'd5;
    localparam logic [2:0] MmioAccess = 3'd6;
    localparam logic [2:0] Done       = 3'd7;

    logic [2:0] state;
    logic       mmioAccess;
    logic       mmioWriteQ;
    logic       apbDone;
    cacheAddrT  lineAddr;

    assign mmioAccess = (read | write) && (addr.raw == `MMIO_ADDR);
    assign apbDone    = apb.psel && apb.penable && apb.pready;

    always_comb begin
        lineAddr          = addr;
        lineAddr.f.offset = 2'b00;  // Word aligned fill
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= Idle;
        end else begin
            case (state)
                Idle: begin
                    if (mmioAccess) begin
                        state <= MmioSetup;
                    end else if (miss.missReq) begin
                        state <= miss.victimDirty ? WbSetup : FillSetup;
                    end
                end
                WbSetup:    state <= WbAccess;
                WbAccess:   state <= apbDone ? FillSetup : WbAccess;
                FillSetup:  state <= FillAccess;
                FillAccess: state <= apbDone ? Done : FillAccess;
                MmioSetup:  state <= MmioAccess;
                MmioAccess: state <= apbDone ? Idle : MmioAccess;
                default:    state <= Idle;  // Done, fill pulse sent
            endcase
        end
    end

    // Transfer payload, captured as the FSM leaves idle
    always_ff @(posedge clk) begin
        if (state == Idle) begin
            if (mmioAccess) begin
                apb.paddr  <= addr.raw;
                apb.pwdata <= storeWord;
                mmioWriteQ <= write;
            end else if (miss.victimDirty) begin
                apb.paddr  <= miss.victimAddr;
                apb.pwdata <= miss.victimData;
            end else begin
                apb.paddr <= lineAddr.raw;
            end
        end else if (state == WbAccess && apbDone) begin
            apb.paddr <= lineAddr.raw;  // Fill follows the writeback
        end
        if (state == FillAccess && apbDone) begin
            miss.fillData <= apb.prdata;
        end
    end

    assign apb.psel    = (state != Idle) && (state != Done);
    assign apb.penable = (state == WbAccess) || (state == FillAccess) || (state == MmioAccess);
    assign apb.pwrite  = (state == WbSetup) || (state == WbAccess) ||
                         (((state == MmioSetup) || (state == MmioAccess)) && mmioWriteQ);

    assign miss.fillValid = (state == Done);

    // MMIO read data goes out in the completion cycle
    assign mmioData = apb.prdata;
    assign mmioBusy = mmioAccess && !((state == MmioAccess) && apbDone);

endmodule

`default_nettype wire

// ==== mainMemory.sv ====
`include "dcache_defs.svh"
`timescale 1ns/10ps
`default_nettype none

module mainMemory (
    input logic clk,
    input logic rst,
    apbIf.slave apb
);
    localparam int IdxW  = $clog2(`MEM_WORDS);
    localparam int CntW  = $clog2(`MEM_WAIT + 2);
    localparam int DataW = `DATA_W;

    logic [`DATA_W-1:0] mem [`MEM_WORDS];
    logic [IdxW-1:0]    idx;
    logic [CntW-1:0]    waitCnt;  // Access cycles so far
    logic               accessPhase;

    assign idx         = apb.paddr[2 +: IdxW];  // Wraps at the memory depth
    assign accessPhase = apb.psel && apb.penable;
    assign apb.pready  = accessPhase && (waitCnt == CntW'(`MEM_WAIT));
    assign apb.prdata  = mem[idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            waitCnt <= '0;
        end else if (apb.pready) begin
            waitCnt <= '0;
        end else if (accessPhase) begin
            waitCnt <= waitCnt + 1'b1;
        end
    end

    // Each word comes out of reset holding its own index
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                mem[i] <= DataW'(i);
            end
        end else if (apb.pready && apb.pwrite) begin
            mem[idx] <= apb.pwdata;
        end
    end

endmodule

`default_nettype wire

// ==== dataCacheTop.sv ====
`include "dcache_defs.svh"
`timescale 1ns/10ps
`default_nettype none

module dataCacheTop (
    input  logic               clk,
    input  logic               rst,
    input  logic               read,
    input  logic               write,
    input  logic [`ADDR_W-1:0] addr,
    input  logic [`DATA_W-1:0] wdata,
    input  logic [2:0]         funct3,
    output logic [`DATA_W-1:0] rdata,
    output logic               stall
);
    import dcache_pkg::*;

    cacheAddrT          cpuAddr;
    logic [`DATA_W-1:0] lineWord;
    logic [`DATA_W-1:0] loadData;
    logic [`DATA_W-1:0] storeWord;
    logic [`DATA_W-1:0] mmioData;
    logic [3:0]         byteEnable;
    logic               hit;
    logic               mmioBusy;
    logic               isMmio;

    apbIf  apb ();
    missIf miss ();

    assign cpuAddr.raw = addr;
    assign isMmio      = (addr == `MMIO_ADDR);

    loadStoreAlign uAlign (
        .funct3     (funct3),
        .offset     (cpuAddr.f.offset),
        .lineWord   (lineWord),
        .wdata      (wdata),
        .loadData   (loadData),
        .storeWord  (storeWord),
        .byteEnable (byteEnable)
    );

    cacheArray uArray (
        .clk        (clk),
        .rst        (rst),
        .read       (read),
        .write      (write),
        .addr       (cpuAddr),
        .storeWord  (storeWord),
        .byteEnable (byteEnable),
        .lineWord   (lineWord),
        .hit        (hit),
        .miss       (miss.cache)
    );

    missController uCtrl (
        .clk       (clk),
        .rst       (rst),
        .read      (read),
        .write     (write),
        .addr      (cpuAddr),
        .storeWord (storeWord),
        .mmioData  (mmioData),
        .mmioBusy  (mmioBusy),
        .miss      (miss.ctrl),
        .apb       (apb.master)
    );

    mainMemory uMem (
        .clk (clk),
        .rst (rst),
        .apb (apb.slave)
    );

    assign rdata = isMmio ? mmioData : (hit ? loadData : '0);
    assign stall = mmioBusy | miss.missReq;  // Held until hit or MMIO completion

endmodule

`default_nettype wire

// ==== dataCache_assertions.sv ====
`include "dcache_defs.svh"
`timescale 1ns/10ps
`default_nettype none

module dataCache_assertions (
    input logic               clk,
    input logic               rst,
    input logic               stall,
    input logic               psel,
    input logic               penable,
    input logic               pwrite,
    input logic               pready,
    input logic [`ADDR_W-1:0] paddr,
    input logic [`DATA_W-1:0] pwdata
);
    int failCount = 0;

    // Setup phase lasts exactly one cycle
    setupThenAccess: assert property (@(posedge clk) disable iff (rst)
        psel && !penable |=> psel && penable)
    else begin
        failCount++;
        $error("APB setup cycle was not followed by an access cycle");
    end

    // Transfer payload frozen until pready completes it
    payloadStable: assert property (@(posedge clk) disable iff (rst)
        psel && !(penable && pready) |=> $stable(paddr) && $stable(pwdata) && $stable(pwrite))
    else begin
        failCount++;
        $error("APB address, write data or direction changed before completion");
    end

    stallLowAfterReset: assert property (@(posedge clk)
        $fell(rst) |-> !stall)
    else begin
        failCount++;
        $error("stall was high in the cycle after reset");
    end

endmodule

bind dataCacheTop dataCache_assertions apbChecks (
    .clk     (clk),
    .rst     (rst),
    .stall   (stall),
    .psel    (apb.psel),
    .penable (apb.penable),
    .pwrite  (apb.pwrite),
    .pready  (apb.pready),
    .paddr   (apb.paddr),
    .pwdata  (apb.pwdata)
);

`default_nettype wire

// ==== tb_dataCache.sv ====
`include "dcache_defs.svh"
`timescale 1ns/10ps
`default_nettype none

module tb_dataCache;
    localparam int IdxW          = $clog2(`MEM_WORDS);
    localparam int AccessTimeout = 100;  // Cycles of stall before giving up

    logic               clk;
    logic               rst;
    logic               read;
    logic               write;
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] wdata;
    logic [2:0]         funct3;
    logic [`DATA_W-1:0] rdata;
    logic               stall;

    logic [`DATA_W-1:0] shadow [`MEM_WORDS];  // What the CPU should see
    int                 checks   = 0;
    int                 errors   = 0;
    int                 timeouts = 0;
    int                 seed;

    dataCacheTop uut (
        .clk    (clk),
        .rst    (rst),
        .read   (read),
        .write  (write),
        .addr   (addr),
        .wdata  (wdata),
        .funct3 (funct3),
        .rdata  (rdata),
        .stall  (stall)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Load result by the RV32I extension rules
    function automatic logic [31:0] expectedLoad(input logic [31:0] word, input logic [2:0] f3,
                                                 input logic [1:0] offset);
        logic [31:0] shifted;
        shifted = word >> (8 * offset);
        case (f3)
            3'b000:  return {{24{shifted[7]}}, shifted[7:0]};    // lb
            3'b001:  return {{16{shifted[15]}}, shifted[15:0]};  // lh
            3'b010:  return word;
            3'b100:  return {24'h0, shifted[7:0]};
            3'b101:  return {16'h0, shifted[15:0]};
            default: return 32'h0;
        endcase
    endfunction

    // Memory word after a store of the given size at the given offset
    function automatic logic [31:0] mergedStore(input logic [31:0] old, input logic [2:0] f3,
                                                input logic [1:0] offset, input logic [31:0] wd);
        logic [31:0] mask;
        case (f3)
            3'b000:  mask = 32'h0000_00FF << (8 * offset);
            3'b001:  mask = 32'h0000_FFFF << (8 * offset);
            3'b010:  mask = 32'hFFFF_FFFF;
            default: mask = 32'h0;
        endcase
        return (old & ~mask) | ((wd << (8 * offset)) & mask);
    endfunction

    task automatic finishRun;
        $display("checks %0d, mismatches %0d, timeouts %0d, protocol failures %0d",
                 checks, errors, timeouts, uut.apbChecks.failCount);
        if (errors == 0 && timeouts == 0 && uut.apbChecks.failCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkStall(input string name, input bit expectStall, input int stallCycles);
        checks++;
        assert ((stallCycles > 0) == expectStall) else begin
            errors++;
            $display("mismatch %s stall: expected %0b, actual %0b", name, expectStall,
                     stallCycles > 0);
        end
    endtask

    // One CPU access held until stall falls
    task automatic runAccess(input bit isStore, input logic [31:0] a, input logic [2:0] f3,
                             input logic [31:0] wd, output logic [31:0] rd,
                             output int stallCycles);
        bit done;
        done        = 1'b0;
        stallCycles = 0;
        rd          = '0;
        @(posedge clk);
        read   <= !isStore;
        write  <= isStore;
        addr   <= a;
        funct3 <= f3;
        wdata  <= wd;
        while (!done && stallCycles <= AccessTimeout) begin
            @(negedge clk);  // Outputs settled here
            if (!stall) begin
                rd   = rdata;
                done = 1'b1;
            end else begin
                stallCycles++;
            end
        end
        if (!done) begin
            timeouts++;
            $display("timeout: stall never fell for the access at address %h", a);
            finishRun();
        end else begin
            @(posedge clk);  // Access commits on this edge
            read  <= 1'b0;
            write <= 1'b0;
        end
    endtask

    task automatic loadAndCheck(input string name, input logic [31:0] a, input logic [2:0] f3,
                                output int stallCycles);
        logic [31:0] got;
        logic [31:0] want;
        want = expectedLoad(shadow[a[2 +: IdxW]], f3, a[1:0]);
        runAccess(1'b0, a, f3, 32'h0, got, stallCycles);
        checkValue(name, want, got);
    endtask

    task automatic storeAndTrack(input logic [31:0] a, input logic [2:0] f3,
                                 input logic [31:0] wd, output int stallCycles);
        logic [31:0] unused;
        runAccess(1'b1, a, f3, wd, unused, stallCycles);
        shadow[a[2 +: IdxW]] = mergedStore(shadow[a[2 +: IdxW]], f3, a[1:0], wd);
    endtask

    initial begin
        int          sc;
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] a;
        logic [1:0]  size;
        logic [1:0]  off;
        rst    = 1'b1;
        read   = 1'b0;
        write  = 1'b0;
        addr   = '0;
        wdata  = '0;
        funct3 = 3'b000;
        seed   = 32'hd5ecad7f;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            shadow[i] = 32'(i);  // Memory reset image
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        loadAndCheck("coldLoadWord", 32'h40, 3'b010, sc);
        checkStall("coldLoadWord", 1'b1, sc);
        loadAndCheck("hitLoadWord", 32'h40, 3'b010, sc);
        checkStall("hitLoadWord", 1'b0, sc);

        // Bytes A5 7F F1 80 with halves 7FA5 and 80F1
        storeAndTrack(32'h44, 3'b010, 32'h80F1_7FA5, sc);
        for (int o = 0; o < 4; o++) begin
            loadAndCheck("loadByteSigned", 32'h44 + 32'(o), 3'b000, sc);
            loadAndCheck("loadByteUnsigned", 32'h44 + 32'(o), 3'b100, sc);
        end
        for (int o = 0; o < 4; o += 2) begin
            loadAndCheck("loadHalfSigned", 32'h44 + 32'(o), 3'b001, sc);
            loadAndCheck("loadHalfUnsigned", 32'h44 + 32'(o), 3'b101, sc);
        end

        storeAndTrack(32'h48, 3'b010, 32'h1122_3344, sc);  // Allocates the line
        storeAndTrack(32'h49, 3'b000, 32'h0000_00AB, sc);
        checkStall("storeByteHit", 1'b0, sc);
        storeAndTrack(32'h4A, 3'b001, 32'h0000_CDEF, sc);
        checkStall("storeHalfHit", 1'b0, sc);
        loadAndCheck("reloadAfterNarrowStores", 32'h48, 3'b010, sc);
        storeAndTrack(32'h4B, 3'b000, 32'h0000_0055, sc);
        storeAndTrack(32'h48, 3'b001, 32'hFFFF_9966, sc);  // Upper half of wdata ignored
        loadAndCheck("reloadAfterMoreStores", 32'h48, 3'b010, sc);
        storeAndTrack(32'h48, 3'b010, 32'hCAFE_F00D, sc);
        checkStall("storeWordHit", 1'b0, sc);
        loadAndCheck("reloadAfterWordStore", 32'h48, 3'b010, sc);

        // Three lines in set 0 force a dirty victim out
        storeAndTrack(32'h50, 3'b010, 32'hA5A5_0050, sc);
        storeAndTrack(32'h60, 3'b010, 32'hA5A5_0060, sc);
        storeAndTrack(32'h70, 3'b010, 32'hA5A5_0070, sc);
        loadAndCheck("evictReloadFirst", 32'h50, 3'b010, sc);
        checkStall("evictReloadFirst", 1'b1, sc);
        loadAndCheck("evictReloadSecond", 32'h60, 3'b010, sc);
        loadAndCheck("evictReloadThird", 32'h70, 3'b010, sc);

        storeAndTrack(`MMIO_ADDR, 3'b010, 32'hDEAD_BEEF, sc);
        checkStall("mmioStore", 1'b1, sc);
        loadAndCheck("mmioLoad", `MMIO_ADDR, 3'b010, sc);
        checkStall("mmioLoad", 1'b1, sc);  // Never cached
        loadAndCheck("set3Neighbour", 32'h1C, 3'b010, sc);

        // Random mix over words 64 to 127 away from the MMIO word
        for (int n = 0; n < 200; n++) begin
            r    = $random(seed);
            d    = $random(seed);
            size = (r[7:6] == 2'b11) ? 2'b10 : r[7:6];
            if (size == 2'b00) begin
                off = r[9:8];
            end else if (size == 2'b01) begin
                off = {r[9], 1'b0};
            end else begin
                off = 2'b00;
            end
            a = 32'h100 | {24'h0, r[5:0], off};
            if (r[10]) begin
                storeAndTrack(a, {1'b0, size}, d, sc);
            end else begin
                loadAndCheck("randomLoad", a, {r[11] & (size != 2'b10), size}, sc);
            end
        end
        for (int w = 64; w < 128; w++) begin
            loadAndCheck("finalSweep", 32'(w) << 2, 3'b010, sc);
        end

        finishRun();
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
dcache_pkg.sv
cacheIfs.sv
loadStoreAlign.sv
cacheArray.sv
missController.sv
mainMemory.sv
dataCacheTop.sv
dataCache_assertions.sv
tb_dataCache.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the data cache testbench, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module tb_dataCache -f tb.f \
    && ./obj_dir/Vtb_dataCache +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
